// ==== rtl/clock_macros.svh ====
`ifndef CLOCK_MACROS_SVH
`define CLOCK_MACROS_SVH

// Default divider counts for a 50 MHz board clock
`define CLK_PER_SEC   50000000
`define CLK_PER_SCAN  5000
`define CLK_PER_KEY   500000

// ----------------------------------------
// Last value of each unit before it wraps
// ----------------------------------------
`define SEC_MAX  6'd59
`define MIN_MAX  6'd59
`define HOU_MAX  6'd23

// Digits on the display
`define NUM_DIGITS  6

`endif

// ==== rtl/clock_pkg.sv ====
package clock_pkg;

	// One time unit, wide enough for 0..59
	typedef logic [5:0] unit_t;

	// Per-unit strobe
	// bit 0 seconds, bit 1 minutes, bit 2 hours
	typedef logic [2:0] unit_sel_t;

	// ----------------------------------------
	// Controller state
	// ----------------------------------------
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SETUP = 2'd1,
		MODE_ALARM = 2'd2
	} mode_e;

	typedef enum logic [1:0] {
		POS_SEC = 2'd0,
		POS_MIN = 2'd1,
		POS_HOU = 2'd2
	} pos_e;

endpackage

// ==== rtl/display_pkg.sv ====
`include "clock_macros.svh"

package display_pkg;

	// Decimal digit 0..9
	typedef logic [3:0] digit_t;

	// Segments a down to g, active high
	typedef logic [6:0] seg_t;

	// Common-anode digit select, active low
	typedef logic [`NUM_DIGITS-1:0] digit_enb_t;

endpackage

// ==== rtl/hms_if.sv ====
`timescale 1ns/100ps

interface hms_if;

	// Current value of each unit
	clock_pkg::unit_t   sec;
	clock_pkg::unit_t   min;
	clock_pkg::unit_t   hou;

	// One-cycle set strobes, one bit per unit
	clock_pkg::unit_sel_t inc;

	modport ctrl (
		output inc
	);

	modport counter (
		output sec, min, hou,
		input  inc
	);

	modport view (
		input  sec, min, hou
	);

endinterface

// ==== rtl/tick_gen.sv ====
`timescale 1ns/100ps

module tick_gen #(
	parameter int DIV = 1000
) (
	input  logic clk,
	input  logic rst_n,
	output logic o_tick
);

	localparam int CW = (DIV > 1) ? $clog2(DIV) : 1;

	logic [CW-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt    <= '0;
			o_tick <= 1'b0;
		end else if (cnt == CW'(DIV - 1)) begin
			cnt    <= '0;
			o_tick <= 1'b1;
		end else begin
			cnt    <= cnt + 1'b1;
			o_tick <= 1'b0;
		end
	end

	// Tick is a single-cycle enable
	a_tick_single: assert property (@(posedge clk) disable iff (!rst_n)
		(DIV > 1) && o_tick |=> !o_tick);

endmodule

// ==== rtl/mode_ctrl.sv ====
`timescale 1ns/100ps

module mode_ctrl (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              i_key_tick,
	input  logic              i_sec_tick,
	input  logic              i_sw_mode,
	input  logic              i_sw_pos,
	input  logic              i_sw_inc,
	input  logic              i_sw_alarm,
	output clock_pkg::mode_e  o_mode,
	output logic              o_alarm_en,
	output logic              o_adv,
	hms_if.ctrl               time_bus,
	hms_if.ctrl               alarm_bus
);

	logic [3:0]           sw_now;
	logic [3:0]           sw_d1;
	logic [3:0]           sw_d2;
	logic [3:0]           press;
	clock_pkg::pos_e      pos;
	clock_pkg::unit_sel_t pos_sel;

	// ----------------------------------------
	// Switch sampling on the key tick
	// ----------------------------------------
	// Bit order: mode, pos, inc, alarm
	assign sw_now = {i_sw_alarm, i_sw_inc, i_sw_pos, i_sw_mode};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sw_d1 <= '1;
			sw_d2 <= '1;
		end else if (i_key_tick) begin
			sw_d1 <= sw_now;
			sw_d2 <= sw_d1;
		end
	end

	// Released sample followed by a pressed one
	assign press = {4{i_key_tick}} & sw_d2 & ~sw_d1;

	// ----------------------------------------
	// Mode, position and alarm enable
	// ----------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode     <= clock_pkg::MODE_CLOCK;
			pos        <= clock_pkg::POS_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			if (press[0]) begin
				case (o_mode)
					clock_pkg::MODE_CLOCK: o_mode <= clock_pkg::MODE_SETUP;
					clock_pkg::MODE_SETUP: o_mode <= clock_pkg::MODE_ALARM;
					default:               o_mode <= clock_pkg::MODE_CLOCK;
				endcase
			end
			if (press[1]) begin
				case (pos)
					clock_pkg::POS_SEC: pos <= clock_pkg::POS_MIN;
					clock_pkg::POS_MIN: pos <= clock_pkg::POS_HOU;
					default:            pos <= clock_pkg::POS_SEC;
				endcase
			end
			if (press[3])
				o_alarm_en <= ~o_alarm_en;
		end
	end

	always_comb begin
		case (pos)
			clock_pkg::POS_MIN: pos_sel = 3'b010;
			clock_pkg::POS_HOU: pos_sel = 3'b100;
			default:            pos_sel = 3'b001;
		endcase
	end

	// Inc press goes to the counter being edited, none in clock mode
	assign time_bus.inc  = (press[2] && o_mode == clock_pkg::MODE_SETUP) ? pos_sel : '0;
	assign alarm_bus.inc = (press[2] && o_mode == clock_pkg::MODE_ALARM) ? pos_sel : '0;

	// Time stands still while being set
	assign o_adv = (o_mode != clock_pkg::MODE_SETUP) && i_sec_tick;

	a_inc_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!((|time_bus.inc) && (|alarm_bus.inc)));

endmodule

// ==== rtl/hms_counter.sv ====
`timescale 1ns/100ps
`include "clock_macros.svh"

module hms_counter #(
	parameter int RUNNING = 1
) (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   i_adv,
	hms_if.counter bus
);

	clock_pkg::unit_t sec_q;
	clock_pkg::unit_t min_q;
	clock_pkg::unit_t hou_q;
	logic             adv;
	logic             sec_wrap;
	logic             min_wrap;

	function automatic clock_pkg::unit_t step(input clock_pkg::unit_t v,
		input clock_pkg::unit_t max);
		return (v == max) ? '0 : v + clock_pkg::unit_t'(1);
	endfunction

	// Alarm counter only moves on its set strobes
	if (RUNNING != 0) begin : g_run
		assign adv = i_adv;
	end else begin : g_hold
		assign adv = 1'b0;
	end

	assign sec_wrap = (sec_q == `SEC_MAX);
	assign min_wrap = (min_q == `MIN_MAX);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sec_q <= '0;
			min_q <= '0;
			hou_q <= '0;
		end else begin
			if (bus.inc[0] || adv)
				sec_q <= step(sec_q, `SEC_MAX);
			if (bus.inc[1] || (adv && sec_wrap))
				min_q <= step(min_q, `MIN_MAX);
			if (bus.inc[2] || (adv && sec_wrap && min_wrap))
				hou_q <= step(hou_q, `HOU_MAX);
		end
	end

	assign bus.sec = sec_q;
	assign bus.min = min_q;
	assign bus.hou = hou_q;

	a_sec_range: assert property (@(posedge clk) disable iff (!rst_n) sec_q <= `SEC_MAX);
	a_min_range: assert property (@(posedge clk) disable iff (!rst_n) min_q <= `MIN_MAX);
	a_hou_range: assert property (@(posedge clk) disable iff (!rst_n) hou_q <= `HOU_MAX);

endmodule

// ==== rtl/clock_core.sv ====
`timescale 1ns/100ps

module clock_core (
	input  logic              clk,
	input  logic              rst_n,
	input  clock_pkg::mode_e  i_mode,
	input  logic              i_alarm_en,
	input  logic              i_adv,
	hms_if.counter            time_bus,
	hms_if.counter            alarm_bus,
	output clock_pkg::unit_t  o_hou,
	output clock_pkg::unit_t  o_min,
	output clock_pkg::unit_t  o_sec,
	output logic              o_alarm
);

	logic match;

	hms_counter #(.RUNNING(1)) u_time_cnt (
		.clk   (clk),
		.rst_n (rst_n),
		.i_adv (i_adv),
		.bus   (time_bus)
	);

	hms_counter #(.RUNNING(0)) u_alarm_cnt (
		.clk   (clk),
		.rst_n (rst_n),
		.i_adv (),
		.bus   (alarm_bus)
	);

	// Alarm time on the display only while editing it
	assign o_sec = (i_mode == clock_pkg::MODE_ALARM) ? alarm_bus.sec : time_bus.sec;
	assign o_min = (i_mode == clock_pkg::MODE_ALARM) ? alarm_bus.min : time_bus.min;
	assign o_hou = (i_mode == clock_pkg::MODE_ALARM) ? alarm_bus.hou : time_bus.hou;

	assign match = (time_bus.sec == alarm_bus.sec) && (time_bus.min == alarm_bus.min)
		&& (time_bus.hou == alarm_bus.hou);

	// Flag latches on a match and holds until the alarm is switched off
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_alarm <= 1'b0;
		else if (!i_alarm_en)
			o_alarm <= 1'b0;
		else if (match)
			o_alarm <= 1'b1;
	end

endmodule

// ==== rtl/seg_scan.sv ====
`timescale 1ns/100ps
`include "clock_macros.svh"

module seg_scan (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    i_scan_tick,
	input  clock_pkg::unit_t        i_hou,
	input  clock_pkg::unit_t        i_min,
	input  clock_pkg::unit_t        i_sec,
	input  clock_pkg::mode_e        i_mode,
	output display_pkg::seg_t       o_seg,
	output logic                    o_seg_dp,
	output display_pkg::digit_enb_t o_seg_enb
);

	localparam int IW = $clog2(`NUM_DIGITS);

	logic [IW-1:0]       idx;
	display_pkg::digit_t digits [`NUM_DIGITS];
	logic                dp;

	function automatic display_pkg::seg_t decode(input display_pkg::digit_t d);
		case (d)
			4'd0:    return 7'b111_1110;
			4'd1:    return 7'b011_0000;
			4'd2:    return 7'b110_1101;
			4'd3:    return 7'b111_1001;
			4'd4:    return 7'b011_0011;
			4'd5:    return 7'b101_1011;
			4'd6:    return 7'b101_1111;
			4'd7:    return 7'b111_0000;
			4'd8:    return 7'b111_1111;
			4'd9:    return 7'b111_0011;
			default: return 7'b000_0000;
		endcase
	endfunction

	// ----------------------------------------
	// Digit split, ones on the even index
	// ----------------------------------------
	assign digits[0] = display_pkg::digit_t'(i_sec % 10);
	assign digits[1] = display_pkg::digit_t'(i_sec / 10);
	assign digits[2] = display_pkg::digit_t'(i_min % 10);
	assign digits[3] = display_pkg::digit_t'(i_min / 10);
	assign digits[4] = display_pkg::digit_t'(i_hou % 10);
	assign digits[5] = display_pkg::digit_t'(i_hou / 10);

	// Mode marks: digit 0 for setup, digit 1 for alarm
	assign dp = ((i_mode == clock_pkg::MODE_SETUP) && (idx == IW'(0)))
		|| ((i_mode == clock_pkg::MODE_ALARM) && (idx == IW'(1)));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			idx <= '0;
		else if (i_scan_tick)
			idx <= (idx == IW'(`NUM_DIGITS - 1)) ? '0 : idx + 1'b1;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_seg     <= '0;
			o_seg_dp  <= 1'b0;
			o_seg_enb <= ~display_pkg::digit_enb_t'(1);
		end else begin
			o_seg     <= decode(digits[idx]);
			o_seg_dp  <= dp;
			o_seg_enb <= ~(display_pkg::digit_enb_t'(1) << idx);
		end
	end

endmodule

// ==== rtl/digital_clock.sv ====
`timescale 1ns/100ps
`include "clock_macros.svh"

module digital_clock #(
	parameter int SEC_DIV  = `CLK_PER_SEC,
	parameter int SCAN_DIV = `CLK_PER_SCAN,
	parameter int KEY_DIV  = `CLK_PER_KEY
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    i_sw_mode,
	input  logic                    i_sw_pos,
	input  logic                    i_sw_inc,
	input  logic                    i_sw_alarm,
	output display_pkg::seg_t       o_seg,
	output logic                    o_seg_dp,
	output display_pkg::digit_enb_t o_seg_enb,
	output logic                    o_alarm
);

	logic             sec_tick;
	logic             scan_tick;
	logic             key_tick;
	logic             adv;
	logic             alarm_en;
	clock_pkg::mode_e mode;
	clock_pkg::unit_t hou;
	clock_pkg::unit_t min;
	clock_pkg::unit_t sec;

	hms_if time_bus ();
	hms_if alarm_bus ();

	// ----------------------------------------
	// Enable ticks, all on clk
	// ----------------------------------------
	tick_gen #(.DIV(SEC_DIV))  u_sec_tick  (.clk(clk), .rst_n(rst_n), .o_tick(sec_tick));
	tick_gen #(.DIV(SCAN_DIV)) u_scan_tick (.clk(clk), .rst_n(rst_n), .o_tick(scan_tick));
	tick_gen #(.DIV(KEY_DIV))  u_key_tick  (.clk(clk), .rst_n(rst_n), .o_tick(key_tick));

	mode_ctrl u_mode_ctrl (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_key_tick (key_tick),
		.i_sec_tick (sec_tick),
		.i_sw_mode  (i_sw_mode),
		.i_sw_pos   (i_sw_pos),
		.i_sw_inc   (i_sw_inc),
		.i_sw_alarm (i_sw_alarm),
		.o_mode     (mode),
		.o_alarm_en (alarm_en),
		.o_adv      (adv),
		.time_bus   (time_bus),
		.alarm_bus  (alarm_bus)
	);

	clock_core u_clock_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_mode     (mode),
		.i_alarm_en (alarm_en),
		.i_adv      (adv),
		.time_bus   (time_bus),
		.alarm_bus  (alarm_bus),
		.o_hou      (hou),
		.o_min      (min),
		.o_sec      (sec),
		.o_alarm    (o_alarm)
	);

	seg_scan u_seg_scan (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_scan_tick (scan_tick),
		.i_hou       (hou),
		.i_min       (min),
		.i_sec       (sec),
		.i_mode      (mode),
		.o_seg       (o_seg),
		.o_seg_dp    (o_seg_dp),
		.o_seg_enb   (o_seg_enb)
	);

endmodule

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen (
	output logic clk,
	output logic rst_n
);

	// 40 ns period
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Reset held for 4 cycles, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
	end

endmodule

// ==== testbench/tb_digital_clock.sv ====
`timescale 1ns/100ps

module tb_digital_clock;

	logic              clk;
	logic              rst_n;
	logic [3:0]        sw;
	display_pkg::seg_t seg;
	logic              seg_dp;
	logic [5:0]        seg_enb;
	logic              alarm;
	logic [31:0]       lcg_state;
	logic [1:0]        dps;
	int                tb_pos;
	int                shown;
	int                passes;
	int                fails;
	string             name_q[$];
	int                exp_q[$];
	int                act_q[$];

	tb_clk_gen u_clk_gen (.clk(clk), .rst_n(rst_n));

	// Switch bits 0 to 3 carry mode, pos, inc and alarm
	digital_clock #(.SEC_DIV(600), .SCAN_DIV(2), .KEY_DIV(4)) i_digital_clock (
		.clk(clk), .rst_n(rst_n), .i_sw_mode(sw[0]), .i_sw_pos(sw[1]),
		.i_sw_inc(sw[2]), .i_sw_alarm(sw[3]), .o_seg(seg), .o_seg_dp(seg_dp),
		.o_seg_enb(seg_enb), .o_alarm(alarm)
	);

	// ----------------------------------------
	// Reference model
	// ----------------------------------------
	function automatic display_pkg::seg_t seg_of(input int d);
		case (d)
			0:       return 7'b1111110;
			1:       return 7'b0110000;
			2:       return 7'b1101101;
			3:       return 7'b1111001;
			4:       return 7'b0110011;
			5:       return 7'b1011011;
			6:       return 7'b1011111;
			7:       return 7'b1110000;
			8:       return 7'b1111111;
			9:       return 7'b1110011;
			default: return 7'b0000000;
		endcase
	endfunction

	// Times are coded hhmmss
	// A negative n steps back in time
	function automatic int advance(input int t, input int n);
		int s;
		s = (t / 10000 * 3600 + t / 100 % 100 * 60 + t % 100 + n + 86400) % 86400;
		return s / 3600 * 10000 + s / 60 % 60 * 100 + s % 60;
	endfunction

	function automatic int next_rand(input int range);
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return int'(lcg_state[30:16]) % range;
	endfunction

	task automatic stop_on_timeout(input string why);
		$display("ERROR: %s", why);
		$display("TEST FAIL");
		$finish;
	endtask

	// Switch low for 6 key periods, then high for 6
	task automatic press(input int b);
		sw[b] = 1'b0;
		repeat (24) @(negedge clk);
		sw[b] = 1'b1;
		repeat (24) @(negedge clk);
	endtask

	task automatic bump(input int p, input int n);
		while (tb_pos != p) begin
			press(1);
			tb_pos = (tb_pos + 1) % 3;
		end
		repeat (n) press(2);
	endtask

	task automatic set_time(input int from, input int to);
		bump(0, (to % 100 - from % 100 + 60) % 60);
		bump(1, (to / 100 % 100 - from / 100 % 100 + 60) % 60);
		bump(2, (to / 10000 - from / 10000 + 24) % 24);
	endtask

	// Scan the six digits and decode them back to hhmmss
	task automatic read_display();
		int d [6];
		int guard;
		for (int k = 0; k < 6; k++) begin
			guard = 0;
			while (seg_enb != ~(6'd1 << k)) begin
				@(negedge clk);
				guard++;
				if (guard > 40)
					stop_on_timeout("digit enable did not come round on the display");
			end
			d[k] = 15;
			for (int v = 0; v < 10; v++)
				if (seg_of(v) == seg)
					d[k] = v;
			if (k < 2)
				dps[k] = seg_dp;
		end
		shown = (d[5] * 10 + d[4]) * 10000 + (d[3] * 10 + d[2]) * 100 + d[1] * 10 + d[0];
	endtask

	task automatic expect_value(input string name, input int exp, input int act);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(act);
	endtask

	// Accept any advance of lo..hi seconds from start
	task automatic expect_advance(input string name, input int start, input int lo,
		input int hi);
		int exp;
		exp = advance(start, hi);
		for (int n = lo; n <= hi; n++)
			if (advance(start, n) == shown)
				exp = advance(start, n);
		expect_value(name, exp, shown);
	endtask

	// ----------------------------------------
	// Compare process
	// ----------------------------------------
	always @(posedge clk) begin
		while (name_q.size() > 0) begin
			assert (act_q[0] == exp_q[0]) begin
				passes++;
				$display("PASS %s", name_q[0]);
			end else begin
				fails++;
				$display("FAIL %s expected %0d actual %0d", name_q[0], exp_q[0], act_q[0]);
			end
			void'(name_q.pop_front());
			void'(exp_q.pop_front());
			void'(act_q.pop_front());
		end
	end

	initial begin
		int t0;
		int n;
		int c0;
		int alarm_t;
		int guard;
		logic seen;
		lcg_state = 32'd20;
		sw = 4'hf;
		tb_pos = 0;
		passes = 0;
		fails = 0;
		repeat (6) @(negedge clk);

		read_display();
		expect_value("reset_time", 0, shown);
		expect_value("reset_dp", 0, dps);
		expect_value("reset_alarm", 0, alarm);

		// Setup mode with the seconds always wrapping past 59
		press(0);
		n = 60 + next_rand(5);
		bump(0, n);
		read_display();
		expect_value("set_sec_wrap", n % 60, shown);
		expect_value("setup_dp", 1, dps);
		t0 = n % 60;
		n = 1 + next_rand(12);
		bump(1, n);
		read_display();
		t0 = t0 + n % 60 * 100;
		expect_value("set_min", t0, shown);
		n = 20 + next_rand(8);
		bump(2, n);
		read_display();
		t0 = t0 + n % 24 * 10000;
		expect_value("set_hou", t0, shown);

		// Run across midnight for about 4 seconds
		set_time(t0, 235958);
		read_display();
		expect_value("set_235958", 235958, shown);
		press(0);
		press(0);
		repeat (2304) @(negedge clk);
		press(0);
		read_display();
		expect_advance("run_wrap", 235958, 2, 5);

		// Alarm setting while the clock keeps running
		t0 = shown;
		c0 = $time;
		press(0);
		alarm_t = next_rand(5) * 10000;
		alarm_t = alarm_t + next_rand(10) * 100;
		alarm_t = alarm_t + next_rand(20);
		set_time(0, alarm_t);
		read_display();
		expect_value("alarm_set", alarm_t, shown);
		expect_value("alarm_dp", 2, dps);
		press(0);
		press(0);
		n = ($time - c0) / 40;
		read_display();
		// Clock ran for n cycles less about one press
		expect_advance("alarm_run", t0, (n - 60) / 600, n / 600 + 1);

		// Enabled alarm three seconds ahead
		set_time(shown, advance(alarm_t, -3));
		press(3);
		press(0);
		press(0);
		guard = 0;
		while (!alarm && guard < 6000) begin
			@(negedge clk);
			guard++;
		end
		expect_value("alarm_raised", 1, alarm);
		press(3);
		expect_value("alarm_cleared", 0, alarm);

		// Disabled alarm through a match
		press(0);
		read_display();
		set_time(shown, advance(alarm_t, -2));
		press(0);
		press(0);
		seen = 1'b0;
		repeat (2400) begin
			@(negedge clk);
			seen |= alarm;
		end
		expect_value("alarm_disabled", 0, seen);

		n = 0;
		while (name_q.size() > 0 && n < 10) begin
			@(negedge clk);
			n++;
		end
		$display("Checks: %0d passed, %0d failed", passes, fails);
		if (fails == 0 && name_q.size() == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+rtl
rtl/clock_pkg.sv
rtl/display_pkg.sv
rtl/hms_if.sv
rtl/tick_gen.sv
rtl/mode_ctrl.sv
rtl/hms_counter.sv
rtl/clock_core.sv
rtl/seg_scan.sv
rtl/digital_clock.sv
testbench/tb_clk_gen.sv
testbench/tb_digital_clock.sv

// ==== Bender.yml ====
package:
  name: digital_clock

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/clock_pkg.sv
      - rtl/display_pkg.sv
      - rtl/hms_if.sv
      - rtl/tick_gen.sv
      - rtl/mode_ctrl.sv
      - rtl/hms_counter.sv
      - rtl/clock_core.sv
      - rtl/seg_scan.sv
      - rtl/digital_clock.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_digital_clock.sv
